// ==== files.f ====
design/xfcp_udp_pkg.sv
design/udp_port_filter.sv
design/reply_header_gen.sv
design/xfcp_skid_buffer.sv
design/xfcp_udp_adapter.sv
testbench/xfcp_udp_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps -f files.f \
    --top-module xfcp_udp_tb -o xfcp_udp_sim
out=$(./obj_dir/xfcp_udp_sim)
echo "$out"
if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

// ==== testbench/xfcp_udp_tb.sv ====
`timescale 1ns/10ps

module xfcp_udp_tb;

    import xfcp_udp_pkg::*;

    // About 150 beats in all, a few cycles each under random stalls, so a wide margin
    localparam int                MAX_CYCLES = 20000;
    localparam logic [PORT_W-1:0] LOCAL_PORT = 16'd14000;
    localparam logic [PORT_W-1:0] OTHER_PORT = 16'd14001;
    localparam logic [IP_W-1:0]   IP_A       = 32'hc0a8_0164;
    localparam logic [PORT_W-1:0] PORT_A     = 16'd50123;
    localparam logic [IP_W-1:0]   IP_B       = 32'h0a00_0007;
    localparam logic [PORT_W-1:0] PORT_B     = 16'd40404;

    logic        clk;
    logic        rst;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    udp_rx_hdr_t rx_hdr;
    logic        rx_valid;
    logic        rx_ready;
    xfcp_beat_t  rx_beat;
    logic        down_out_valid;
    logic        down_out_ready;
    xfcp_beat_t  down_out_beat;
    logic        down_in_valid;
    logic        down_in_ready;
    xfcp_beat_t  down_in_beat;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    reply_addr_t tx_hdr;
    logic        tx_valid;
    logic        tx_ready;
    xfcp_beat_t  tx_beat;

    xfcp_beat_t        sent_q[$];
    xfcp_beat_t        got_q[$];
    bit                stall_down;
    bit                up_done;
    int                hdr_count;
    int                cycles = 0;
    int                checks = 0;
    int                errors = 0;

    xfcp_udp_adapter i_xfcp_udp_adapter (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr_valid   (rx_hdr_valid),
        .rx_hdr_ready   (rx_hdr_ready),
        .rx_hdr         (rx_hdr),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_beat        (rx_beat),
        .down_out_valid (down_out_valid),
        .down_out_ready (down_out_ready),
        .down_out_beat  (down_out_beat),
        .down_in_valid  (down_in_valid),
        .down_in_ready  (down_in_ready),
        .down_in_beat   (down_in_beat),
        .tx_hdr_valid   (tx_hdr_valid),
        .tx_hdr_ready   (tx_hdr_ready),
        .tx_hdr         (tx_hdr),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .tx_beat        (tx_beat),
        .local_port     (LOCAL_PORT)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // Tasks below start and return on a falling edge
    task automatic send_rx_frame(input logic [IP_W-1:0] ip, input logic [PORT_W-1:0] src_port,
                                 input logic [PORT_W-1:0] dest_port, input int len,
                                 input bit keep);
        xfcp_beat_t beat;
        bit         done;
        rx_hdr       = '{src_ip: ip, src_port: src_port, dest_port: dest_port};
        rx_hdr_valid = 1'b1;
        do begin
            #1;
            done = rx_hdr_ready;
            @(negedge clk);
        end while (!done);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            beat.data = BYTE_W'($urandom);
            beat.last = (i == len - 1);
            beat.user = 1'($urandom % 2);
            rx_valid  = 1'b1;
            rx_beat   = beat;
            if (keep) begin
                sent_q.push_back(beat);
            end
            do begin
                #1;
                done = rx_ready;
                @(negedge clk);
            end while (!done);
        end
        rx_valid = 1'b0;
    endtask

    task automatic collect_down_frame();
        bit done;
        done = 1'b0;
        got_q.delete();
        while (!done) begin
            down_out_ready = stall_down ? 1'($urandom % 2) : 1'b1;
            #1;
            if (down_out_valid && down_out_ready) begin
                got_q.push_back(down_out_beat);
                done = down_out_beat.last;
            end
            @(negedge clk);
        end
        down_out_ready = 1'b1;
    endtask

    task automatic check_down_frame(input string name);
        compare_value({name, " length"}, 64'(sent_q.size()), 64'(got_q.size()));
        for (int i = 0; i < got_q.size() && i < sent_q.size(); i++) begin
            compare_value({name, " data"}, 64'(sent_q[i].data), 64'(got_q[i].data));
            compare_value({name, " last"}, 64'(i == sent_q.size() - 1), 64'(got_q[i].last));
            compare_value({name, " user"}, 64'(sent_q[i].user), 64'(got_q[i].user));
        end
    endtask

    task automatic send_up_frame(input string name, input int len);
        logic [BYTE_W-1:0] data;
        logic              user;
        bit                done;
        for (int i = 0; i < len; i++) begin
            data          = BYTE_W'($urandom);
            user          = 1'($urandom % 2);
            down_in_valid = 1'b1;
            down_in_beat  = '{data: data, last: (i == len - 1), user: user};
            do begin
                tx_ready = ($urandom % 4) != 0;
                #1;
                compare_value({name, " tx_valid"}, 64'd1, 64'(tx_valid));
                compare_value({name, " tx_beat data"}, 64'(data), 64'(tx_beat.data));
                compare_value({name, " tx_beat last"}, 64'(i == len - 1), 64'(tx_beat.last));
                compare_value({name, " tx_beat user"}, 64'(user), 64'(tx_beat.user));
                compare_value({name, " down_in_ready"}, 64'(tx_ready), 64'(down_in_ready));
                done = tx_ready;
                @(negedge clk);
            end while (!done);
        end
        down_in_valid = 1'b0;
        tx_ready      = 1'b1;
    endtask

    // Counts header transfers, holding ready low for the first hold cycles of each
    task automatic watch_tx_hdr(input string name, input int hold, input reply_addr_t addr);
        int stalls;
        int idle;
        bit pending;
        stalls    = 0;
        idle      = 0;
        pending   = 1'b0;
        hdr_count = 0;
        while (!(up_done && idle >= 4)) begin
            tx_hdr_ready = (stalls >= hold);
            #1;
            if (pending) begin
                compare_value({name, " tx_hdr_valid held"}, 64'd1, 64'(tx_hdr_valid));
            end
            if (tx_hdr_valid) begin
                compare_value({name, " tx_hdr ip"}, 64'(addr.ip), 64'(tx_hdr.ip));
                compare_value({name, " tx_hdr port"}, 64'(addr.port), 64'(tx_hdr.port));
                idle = 0;
                if (tx_hdr_ready) begin
                    hdr_count++;
                    pending = 1'b0;
                    stalls  = 0;
                end else begin
                    pending = 1'b1;
                    stalls++;
                end
            end else if (up_done) begin
                idle++;
            end
            @(negedge clk);
        end
        tx_hdr_ready = 1'b0;
    endtask

    task automatic test_reset();
        int errs;
        errs = errors;
        rst  = 1'b1;
        repeat (3) begin
            @(negedge clk);
            compare_value("reset down_out_valid", 64'd0, 64'(down_out_valid));
            compare_value("reset tx_hdr_valid", 64'd0, 64'(tx_hdr_valid));
            compare_value("reset rx_hdr_ready", 64'd0, 64'(rx_hdr_ready));
            compare_value("reset rx_ready", 64'd0, 64'(rx_ready));
        end
        rst = 1'b0;
        @(negedge clk);
        compare_value("reset rx_hdr_ready after release", 64'd1, 64'(rx_hdr_ready));
        compare_value("reset down_out_valid after release", 64'd0, 64'(down_out_valid));
        compare_value("reset tx_hdr_valid after release", 64'd0, 64'(tx_hdr_valid));
        report_test("reset", errs);
    endtask

    task automatic test_match();
        int errs;
        errs = errors;
        sent_q.delete();
        fork
            send_rx_frame(IP_A, PORT_A, LOCAL_PORT, 16, 1'b1);
            collect_down_frame();
        join
        check_down_frame("matching frame");
        report_test("matching frame", errs);
    endtask

    task automatic test_foreign();
        int errs;
        errs = errors;
        sent_q.delete();
        // A leaked foreign beat would show up ahead of the matching frame
        fork
            begin
                send_rx_frame(IP_B, PORT_B, OTHER_PORT, 16, 1'b0);
                send_rx_frame(IP_A, PORT_A, LOCAL_PORT, 16, 1'b1);
            end
            collect_down_frame();
        join
        check_down_frame("foreign frame");
        report_test("foreign frame", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs       = errors;
        stall_down = 1'b1;
        sent_q.delete();
        fork
            send_rx_frame(IP_A, PORT_A, LOCAL_PORT, 64, 1'b1);
            collect_down_frame();
        join
        stall_down = 1'b0;
        check_down_frame("back-pressure");
        report_test("back-pressure", errs);
    endtask

    // New matching sender, then a foreign frame from the earlier one
    task automatic test_reply_addr();
        int errs;
        errs = errors;
        send_rx_frame(IP_B, PORT_B, LOCAL_PORT, 8, 1'b0);
        send_rx_frame(IP_A, PORT_A, OTHER_PORT, 8, 1'b0);
        up_done = 1'b0;
        fork
            begin
                send_up_frame("reply address", 4);
                up_done = 1'b1;
            end
            watch_tx_hdr("reply address", 5, '{ip: IP_B, port: PORT_B});
        join
        compare_value("reply address header count", 64'd1, 64'(hdr_count));
        report_test("reply address", errs);
    endtask

    task automatic test_upstream();
        int errs;
        errs    = errors;
        up_done = 1'b0;
        fork
            begin
                send_up_frame("upstream", 5);
                send_up_frame("upstream", 7);
                up_done = 1'b1;
            end
            watch_tx_hdr("upstream", 0, '{ip: IP_B, port: PORT_B});
        join
        compare_value("upstream header count", 64'd2, 64'(hdr_count));
        report_test("upstream", errs);
    endtask

    initial begin
        void'($urandom(61950));
        rst            = 1'b1;
        rx_hdr_valid   = 1'b0;
        rx_hdr         = '0;
        rx_valid       = 1'b0;
        rx_beat        = '0;
        down_out_ready = 1'b1;
        down_in_valid  = 1'b0;
        down_in_beat   = '0;
        tx_hdr_ready   = 1'b0;
        tx_ready       = 1'b1;
        stall_down     = 1'b0;
        up_done        = 1'b0;

        test_reset();
        test_match();
        test_foreign();
        test_backpressure();
        test_reply_addr();
        test_upstream();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== design/xfcp_udp_adapter.sv ====
`timescale 1ns/10ps

module xfcp_udp_adapter (
    input  logic                              clk,
    input  logic                              rst,

    // UDP receive side
    input  logic                              rx_hdr_valid,
    output logic                              rx_hdr_ready,
    input  xfcp_udp_pkg::udp_rx_hdr_t         rx_hdr,
    input  logic                              rx_valid,
    output logic                              rx_ready,
    input  xfcp_udp_pkg::xfcp_beat_t          rx_beat,

    // XFCP downstream output
    output logic                              down_out_valid,
    input  logic                              down_out_ready,
    output xfcp_udp_pkg::xfcp_beat_t          down_out_beat,

    // XFCP upstream input
    input  logic                              down_in_valid,
    output logic                              down_in_ready,
    input  xfcp_udp_pkg::xfcp_beat_t          down_in_beat,

    // UDP transmit side
    output logic                              tx_hdr_valid,
    input  logic                              tx_hdr_ready,
    output xfcp_udp_pkg::reply_addr_t         tx_hdr,
    output logic                              tx_valid,
    input  logic                              tx_ready,
    output xfcp_udp_pkg::xfcp_beat_t          tx_beat,

    input  logic [xfcp_udp_pkg::PORT_W-1:0]   local_port
);

    import xfcp_udp_pkg::*;

    logic        accept;
    reply_addr_t accept_addr;
    logic        int_valid;
    xfcp_beat_t  int_beat;
    logic        ready_early;

    // Upstream payload goes out unchanged
    assign tx_valid      = down_in_valid;
    assign tx_beat       = down_in_beat;
    assign down_in_ready = tx_ready;

    udp_port_filter i_udp_port_filter (
        .clk         (clk),
        .rst         (rst),
        .hdr_valid   (rx_hdr_valid),
        .hdr_ready   (rx_hdr_ready),
        .hdr         (rx_hdr),
        .in_valid    (rx_valid),
        .in_ready    (rx_ready),
        .in_beat     (rx_beat),
        .local_port  (local_port),
        .accept      (accept),
        .accept_addr (accept_addr),
        .int_valid   (int_valid),
        .int_beat    (int_beat),
        .ready_early (ready_early)
    );

    reply_header_gen i_reply_header_gen (
        .clk           (clk),
        .rst           (rst),
        .accept        (accept),
        .accept_addr   (accept_addr),
        .down_in_valid (down_in_valid),
        .down_in_last  (down_in_beat.last),
        .tx_ready      (tx_ready),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_hdr        (tx_hdr)
    );

    xfcp_skid_buffer i_xfcp_skid_buffer (
        .clk         (clk),
        .rst         (rst),
        .int_valid   (int_valid),
        .int_beat    (int_beat),
        .ready_early (ready_early),
        .out_valid   (down_out_valid),
        .out_ready   (down_out_ready),
        .out_beat    (down_out_beat)
    );

endmodule

// ==== design/xfcp_skid_buffer.sv ====
`timescale 1ns/10ps

module xfcp_skid_buffer (
    input  logic                       clk,
    input  logic                       rst,

    // Producer side
    input  logic                       int_valid,
    input  xfcp_udp_pkg::xfcp_beat_t   int_beat,
    output logic                       ready_early,

    // Registered output
    output logic                       out_valid,
    input  logic                       out_ready,
    output xfcp_udp_pkg::xfcp_beat_t   out_beat
);

    import xfcp_udp_pkg::*;

    logic       ready_reg;
    logic       out_valid_next;
    xfcp_beat_t temp_beat;
    logic       temp_valid;
    logic       temp_valid_next;
    logic       store_int_to_out;
    logic       store_int_to_temp;
    logic       store_temp_to_out;

    // Ready next cycle unless the skid entry would fill up
    assign ready_early = out_ready || (!temp_valid && (!out_valid || !int_valid));

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_int_to_out  = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_reg) begin
            if (out_ready || !out_valid) begin
                // Output free, load it directly
                out_valid_next   = int_valid;
                store_int_to_out = 1'b1;
            end else begin
                // Output stalled, park the beat
                temp_valid_next   = int_valid;
                store_int_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // Producer held off, drain the skid entry
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            ready_reg  <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            ready_reg  <= ready_early;
        end
    end

    // Beat storage
    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            out_beat <= int_beat;
        end else if (store_temp_to_out) begin
            out_beat <= temp_beat;
        end

        if (store_int_to_temp) begin
            temp_beat <= int_beat;
        end
    end

endmodule

// ==== design/reply_header_gen.sv ====
`timescale 1ns/10ps

module reply_header_gen (
    input  logic                        clk,
    input  logic                        rst,

    // Sender address from the receive side
    input  logic                        accept,
    input  xfcp_udp_pkg::reply_addr_t   accept_addr,

    // Upstream stream as seen on the transmit side
    input  logic                        down_in_valid,
    input  logic                        down_in_last,
    input  logic                        tx_ready,

    // Transmit header
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output xfcp_udp_pkg::reply_addr_t   tx_hdr
);

    logic frame_reg;
    logic frame_next;
    logic hdr_valid_next;
    logic beat_xfer;

    // Payload passes straight through, so tx_ready is the upstream ready
    assign beat_xfer = down_in_valid && tx_ready;

    always_comb begin
        hdr_valid_next = tx_hdr_valid && !tx_hdr_ready;
        frame_next     = frame_reg;

        // First valid beat of a frame raises one header strobe
        if (!frame_reg && down_in_valid) begin
            frame_next     = 1'b1;
            hdr_valid_next = 1'b1;
        end

        // Also covers a single-beat frame
        if (beat_xfer && down_in_last) begin
            frame_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_reg    <= 1'b0;
            tx_hdr_valid <= 1'b0;
        end else begin
            frame_reg    <= frame_next;
            tx_hdr_valid <= hdr_valid_next;
        end
    end

    // Reply address, kept across foreign frames
    always_ff @(posedge clk) begin
        if (accept) begin
            tx_hdr <= accept_addr;
        end
    end

endmodule

// ==== design/udp_port_filter.sv ====
`timescale 1ns/10ps

module udp_port_filter (
    input  logic                              clk,
    input  logic                              rst,

    // Received UDP header
    input  logic                              hdr_valid,
    output logic                              hdr_ready,
    input  xfcp_udp_pkg::udp_rx_hdr_t         hdr,

    // Received UDP payload
    input  logic                              in_valid,
    output logic                              in_ready,
    input  xfcp_udp_pkg::xfcp_beat_t          in_beat,

    input  logic [xfcp_udp_pkg::PORT_W-1:0]   local_port,

    // Sender of the current matching frame
    output logic                              accept,
    output xfcp_udp_pkg::reply_addr_t         accept_addr,

    // Towards the skid buffer
    output logic                              int_valid,
    output xfcp_udp_pkg::xfcp_beat_t          int_beat,
    input  logic                              ready_early
);

    logic frame_reg;
    logic frame_next;
    logic enable_reg;
    logic enable_next;
    logic hdr_xfer;
    logic last_xfer;
    logic port_match;

    assign hdr_xfer   = hdr_valid && hdr_ready;
    assign last_xfer  = in_valid && in_ready && in_beat.last;
    assign port_match = (hdr.dest_port == local_port);

    // Matching header hands its sender over as the reply address
    assign accept           = hdr_xfer && port_match;
    assign accept_addr.ip   = hdr.src_ip;
    assign accept_addr.port = hdr.src_port;

    // Foreign payload is drained at full rate but never forwarded
    assign int_valid = in_valid && in_ready && enable_reg;
    assign int_beat  = in_beat;

    always_comb begin
        frame_next  = frame_reg;
        enable_next = enable_reg;

        // Header and last beat never coincide, ready is exclusive
        if (hdr_xfer) begin
            frame_next  = 1'b1;
            enable_next = port_match;
        end else if (last_xfer) begin
            frame_next  = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_reg  <= 1'b0;
            enable_reg <= 1'b0;
            hdr_ready  <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            frame_reg  <= frame_next;
            enable_reg <= enable_next;
            // Header side open only between frames
            hdr_ready  <= !frame_next;
            // Payload side follows the buffer while a frame is open
            in_ready   <= ready_early && frame_next;
        end
    end

endmodule

// ==== design/xfcp_udp_pkg.sv ====
package xfcp_udp_pkg;

    // XFCP runs over a byte stream
    localparam int BYTE_W = 8;
    localparam int IP_W   = 32;
    localparam int PORT_W = 16;

    // One stream beat, user flags a bad frame
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              last;
        logic              user;
    } xfcp_beat_t;

    // Received UDP header, only the fields the adapter looks at
    typedef struct packed {
        logic [IP_W-1:0]   src_ip;
        logic [PORT_W-1:0] src_port;
        logic [PORT_W-1:0] dest_port;
    } udp_rx_hdr_t;

    // Destination of a transmitted reply
    typedef struct packed {
        logic [IP_W-1:0]   ip;
        logic [PORT_W-1:0] port;
    } reply_addr_t;

endpackage
